//--- hw/video_timing_pkg.sv
////////////////////////////////////////////////////////////
// one fixed timing set per chip: pal 29 mhz, both ntsc 26 mhz
// chip code 3 is unused and falls back to pal timing
////////////////////////////////////////////////////////////
`default_nettype none

package video_timing_pkg;

    typedef enum logic [1:0] {
        chip_pal      = 2'd0,  // 6569
        chip_ntsc_r8  = 2'd1,  // 6567r8
        chip_ntsc_r56 = 2'd2   // 6567r56a
    } chip_kind_t;

    typedef logic [10:0] hpos_t;  // output x, doubled width
    typedef logic [9:0]  vpos_t;  // output y, doubled height

    typedef struct packed {
        hpos_t max_width;   // last h value before wrap
        hpos_t ha_end;
        hpos_t hs_sta;
        hpos_t hs_end;
        hpos_t ha_sta;
        vpos_t max_height;  // last v value before wrap
        vpos_t va_end;
        vpos_t vs_sta;
        vpos_t vs_end;
        vpos_t va_sta;
        hpos_t x_offset;    // added to h for the line buffer read
    } timing_t;

    // field order: h limits, v limits, then read offset
    function automatic timing_t timing_for(input chip_kind_t kind);
        timing_t t;
        case (kind)
            chip_ntsc_r8:  // 845 wide, 526 high, v window wraps
                t = '{11'd844, 11'd826, 11'd11, 11'd75, 11'd86,
                      10'd525, 10'd26, 10'd28, 10'd50, 10'd52, 11'd140};
            chip_ntsc_r56: // 832 wide, 524 high
                t = '{11'd831, 11'd814, 11'd2, 11'd66, 11'd78,
                      10'd523, 10'd28, 10'd30, 10'd52, 10'd54, 11'd150};
            default:       // pal, 945 wide, 624 high
                t = '{11'd944, 11'd914, 11'd0, 11'd64, 11'd132,
                      10'd623, 10'd592, 10'd7, 10'd12, 10'd17, 11'd70};
        endcase
        return t;
    endfunction

endpackage

`default_nettype wire

//--- hw/pixel_pkg.sv
////////////////////////////////////////////////////////////
// line buffer sized for the widest doubled raster line
////////////////////////////////////////////////////////////
`default_nettype none

package pixel_pkg;

    // c64 palette index
    typedef logic [3:0] color_t;

    // covers max_width plus x_offset, wraps mod depth
    typedef logic [10:0] line_addr_t;

    // one entry per address
    localparam int LINE_DEPTH = 2048;

endpackage

`default_nettype wire

//--- hw/scan_if.sv
////////////////////////////////////////////////////////////
// output scan position, all signals in the clk_dvi domain
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface scan_if;
    import video_timing_pkg::*;

    hpos_t h_count;     // output x
    vpos_t v_count;     // output y
    logic  half_bright; // alternate line flag
    logic  line_wrap;   // high while h_count == max_width

    // driven by the counter
    modport source (output h_count, v_count, half_bright, line_wrap);

    // sync decode and line buffer read
    modport sink (input h_count, v_count, half_bright, line_wrap);

endinterface

`default_nettype wire

//--- hw/scan_counter.sv
////////////////////////////////////////////////////////////
// free running raster counter, no back-pressure
// timing must stay stable outside reset
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module scan_counter (
    input  wire                       clk_dvi,
    input  wire                       rst,     // sync, active low
    input  video_timing_pkg::timing_t timing,
    scan_if.source                    scan
);
    import video_timing_pkg::*;

    hpos_t h_q;
    vpos_t v_q;
    logic  hb_q;  // half bright toggle

    assign scan.h_count     = h_q;
    assign scan.v_count     = v_q;
    assign scan.half_bright = hb_q;
    assign scan.line_wrap   = (h_q == timing.max_width); // last pixel of the row

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            h_q  <= '0;
            v_q  <= '0;
            hb_q <= 1'b0;
        end else if (scan.line_wrap) begin
            h_q <= '0;
            // each stored line spans two output rows
            if (v_q == timing.max_height) begin
                v_q  <= '0;
                hb_q <= 1'b0;  // frame restarts on the bright row
            end else begin
                v_q  <= v_q + 10'd1;
                hb_q <= ~hb_q;
            end
        end else begin
            h_q <= h_q + 11'd1;
        end
    end

endmodule

`default_nettype wire

//--- hw/line_store.sv
////////////////////////////////////////////////////////////
// double line buffer, writes and reads both on clk_dvi
// pixel_out lags the addressing h_count by two cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module line_store #(
    parameter int COLOR_BITS = $bits(pixel_pkg::color_t)
) (
    input  wire                         clk_dvi,
    input  wire                         rst,        // sync, active low
    input  wire                         pixel_we,   // one write per strobed cycle
    input  pixel_pkg::line_addr_t       pixel_x,
    input  wire        [COLOR_BITS-1:0] pixel_in,
    input  wire                         line_start,
    input  video_timing_pkg::hpos_t     x_offset,
    scan_if.sink                        scan,
    output logic       [COLOR_BITS-1:0] pixel_out
);
    import pixel_pkg::*;

    logic                  wr_sel;      // buffer being written
    logic                  rd_sel_q;    // buffer read last cycle
    line_addr_t            rd_addr;
    logic [COLOR_BITS-1:0] rd_data [2]; // registered ram outputs

    // wraps mod LINE_DEPTH, offset trims the left border
    assign rd_addr = line_addr_t'(scan.h_count + x_offset);

    // swap on the cycle after line_start
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            wr_sel <= 1'b0;
        end else if (line_start) begin
            wr_sel <= ~wr_sel;
        end
    end

    // two identical buffers, only one takes writes
    for (genvar b = 0; b < 2; b++) begin : g_buf
        logic [COLOR_BITS-1:0] mem [LINE_DEPTH];

        always_ff @(posedge clk_dvi) begin
            if (pixel_we && (wr_sel == 1'(b))) begin
                mem[pixel_x] <= pixel_in;
            end
            rd_data[b] <= mem[rd_addr];  // first read stage
        end
    end

    // mux select follows the ram read by one cycle
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            rd_sel_q  <= 1'b1;
            pixel_out <= '0;
        end else begin
            rd_sel_q  <= ~wr_sel;
            pixel_out <= rd_data[rd_sel_q]; // second stage
        end
    end

endmodule

`default_nettype wire

//--- hw/sync_shaper.sv
////////////////////////////////////////////////////////////
// sync and window decode, one cycle behind the scan counter
// vertical edges fall on whole output rows only
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module sync_shaper (
    input  wire                       clk_dvi,
    input  wire                       rst,          // sync, active low
    input  video_timing_pkg::timing_t timing,
    input  wire                       hpolarity,    // 1 = active high
    input  wire                       vpolarity,
    input  wire                       enable_csync, // both syncs on hsync
    scan_if.sink                      scan,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      active
);

    logic hs_raw;  // active high forms
    logic vs_raw;
    logic cs_raw;
    logic h_win;
    logic v_win;
    logic hs_pol;  // after polarity
    logic vs_pol;
    logic cs_pol;

    assign hs_raw = (scan.h_count >= timing.hs_sta) && (scan.h_count < timing.hs_end);
    assign vs_raw = (scan.v_count >= timing.vs_sta) && (scan.v_count < timing.vs_end);
    assign cs_raw = hs_raw | vs_raw;

    // active h is exclusive at the start, inclusive at the end
    assign h_win = (scan.h_count > timing.ha_sta) && (scan.h_count <= timing.ha_end);

    // ntsc windows cross the v wrap
    always_comb begin
        if (timing.va_sta < timing.va_end) begin
            v_win = (scan.v_count >= timing.va_sta) && (scan.v_count < timing.va_end);
        end else begin
            v_win = (scan.v_count >= timing.va_sta) || (scan.v_count < timing.va_end);
        end
    end

    assign hs_pol = hpolarity ? hs_raw : ~hs_raw;
    assign vs_pol = vpolarity ? vs_raw : ~vs_raw;
    assign cs_pol = hpolarity ? cs_raw : ~cs_raw; // csync takes h polarity

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            active <= 1'b0;
        end else begin
            hsync  <= enable_csync ? cs_pol : hs_pol;
            vsync  <= enable_csync ? 1'b0 : vs_pol;  // unused line held low
            active <= h_win & v_win;
        end
    end

endmodule

`default_nettype wire

//--- hw/dvi_line_doubler.sv
////////////////////////////////////////////////////////////
// chip_kind must stay stable outside reset
// source writes one native line, line_start swaps buffers
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dvi_line_doubler #(
    parameter int COLOR_BITS = $bits(pixel_pkg::color_t)
) (
    input  wire                           clk_dvi,
    input  wire                           rst,          // sync, active low
    input  video_timing_pkg::chip_kind_t  chip_kind,
    input  wire                           pixel_we,
    input  pixel_pkg::line_addr_t         pixel_x,
    input  wire          [COLOR_BITS-1:0] pixel_in,
    input  wire                           line_start,   // one cycle pulse
    input  wire                           hpolarity,
    input  wire                           vpolarity,
    input  wire                           enable_csync,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          active,
    output logic         [COLOR_BITS-1:0] pixel_out,
    output logic                          half_bright
);
    import video_timing_pkg::*;

    timing_t timing;  // fixed per chip, no registers

    scan_if scan ();

    assign timing      = timing_for(chip_kind);
    assign half_bright = scan.half_bright;

    scan_counter u_scan_counter (
        .clk_dvi (clk_dvi),
        .rst     (rst),
        .timing  (timing),
        .scan    (scan.source)
    );

    line_store #(
        .COLOR_BITS (COLOR_BITS)
    ) u_line_store (
        .clk_dvi    (clk_dvi),
        .rst        (rst),
        .pixel_we   (pixel_we),
        .pixel_x    (pixel_x),
        .pixel_in   (pixel_in),
        .line_start (line_start),
        .x_offset   (timing.x_offset),
        .scan       (scan.sink),
        .pixel_out  (pixel_out)
    );

    sync_shaper u_sync_shaper (
        .clk_dvi      (clk_dvi),
        .rst          (rst),
        .timing       (timing),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .scan         (scan.sink),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active)
    );

endmodule

`default_nettype wire

//--- tests/tb_dvi_line_doubler.sv
////////////////////////////////////////////////////////////
// reference timing kept locally, indexed by chip code 0..2
// full frames per chip, so runs take a few million cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_dvi_line_doubler;

    localparam int PERIOD = 40;
    localparam int SEED   = 52;
    // per chip: pal, ntsc r8, ntsc r56
    localparam int MAX_W  [3] = '{944, 844, 831};
    localparam int HA_END [3] = '{914, 826, 814};
    localparam int HS_STA [3] = '{0, 11, 2};
    localparam int HS_END [3] = '{64, 75, 66};
    localparam int HA_STA [3] = '{132, 86, 78};
    localparam int MAX_H  [3] = '{623, 525, 523};
    localparam int VA_END [3] = '{592, 26, 28};
    localparam int VS_STA [3] = '{7, 28, 30};
    localparam int VS_END [3] = '{12, 50, 52};
    localparam int VA_STA [3] = '{17, 52, 54};
    localparam int X_OFF  [3] = '{70, 140, 150};

    logic clk_dvi = 1'b0;
    logic rst = 1'b0;
    video_timing_pkg::chip_kind_t chip_kind = video_timing_pkg::chip_pal;
    logic pixel_we = 1'b0;
    logic [10:0] pixel_x = '0;
    logic [3:0] pixel_in = '0;
    logic line_start = 1'b0;
    logic hpolarity = 1'b1;
    logic vpolarity = 1'b1;
    logic enable_csync = 1'b0;
    logic hsync, vsync, active, half_bright;
    logic [3:0] pixel_out;

    int ck = 0;                    // chip index for the tables
    int m_h, m_v, h_d1, h_d2;      // predicted scan position and its delay line
    bit m_hb, e_hs, e_vs, e_act;   // expected outputs
    bit started, in_reset, pix_chk, timed_out;
    int errors, n_tests, n_failed;
    logic [3:0] line_a [2048];     // line shown while pix_chk is set

    always #(PERIOD / 2) clk_dvi = ~clk_dvi;

    dvi_line_doubler uut (
        .clk_dvi (clk_dvi), .rst (rst), .chip_kind (chip_kind),
        .pixel_we (pixel_we), .pixel_x (pixel_x), .pixel_in (pixel_in),
        .line_start (line_start), .hpolarity (hpolarity), .vpolarity (vpolarity),
        .enable_csync (enable_csync), .hsync (hsync), .vsync (vsync),
        .active (active), .pixel_out (pixel_out), .half_bright (half_bright)
    );

    function automatic bit in_span(input int x, input int lo, input int hi);
        return (x >= lo) && (x < hi);  // half open [lo, hi)
    endfunction

    // predicted raster, outputs one cycle behind the position
    always @(posedge clk_dvi) begin : ref_model
        bit hr, vr, hw, vw;
        hr = in_span(m_h, HS_STA[ck], HS_END[ck]);
        vr = in_span(m_v, VS_STA[ck], VS_END[ck]);
        hw = (m_h > HA_STA[ck]) && (m_h <= HA_END[ck]);
        if (VA_STA[ck] < VA_END[ck]) begin
            vw = in_span(m_v, VA_STA[ck], VA_END[ck]);
        end else begin
            vw = (m_v >= VA_STA[ck]) || (m_v < VA_END[ck]);  // window across the v wrap
        end
        started  <= 1'b1;
        in_reset <= !rst;
        h_d1     <= m_h;
        h_d2     <= h_d1;  // pixel_out lags by two
        if (!rst) begin
            m_h   <= 0;
            m_v   <= 0;
            m_hb  <= 1'b0;
            e_hs  <= 1'b0;
            e_vs  <= 1'b0;
            e_act <= 1'b0;
        end else begin
            e_hs  <= (enable_csync ? (hr | vr) : hr) ^ !hpolarity;
            e_vs  <= enable_csync ? 1'b0 : (vr ^ !vpolarity);
            e_act <= hw && vw;
            if (m_h == MAX_W[ck]) begin
                m_h <= 0;
                m_v <= (m_v == MAX_H[ck]) ? 0 : m_v + 1;
                m_hb <= (m_v == MAX_H[ck]) ? 1'b0 : !m_hb;
            end else begin
                m_h <= m_h + 1;
            end
        end
    end

    task automatic flag_value(input string name, input int got, input int exp);
        errors++;
        $display("Fail %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
    endtask

    // outputs settle after the rising edge, compare mid cycle
    always @(negedge clk_dvi) begin
        if (started) begin
            assert (hsync === e_hs) else flag_value("hsync", int'(hsync), int'(e_hs));
            assert (vsync === e_vs) else flag_value("vsync", int'(vsync), int'(e_vs));
            assert (active === e_act) else flag_value("active", int'(active), int'(e_act));
            assert (half_bright === m_hb)
                else flag_value("half_bright", int'(half_bright), int'(m_hb));
            if (in_reset) begin
                assert (pixel_out === 4'h0) else flag_value("pixel_out", int'(pixel_out), 0);
            end
            if (pix_chk) begin
                assert (pixel_out === line_a[(h_d2 + X_OFF[ck]) % 2048])
                    else flag_value("pixel_out", int'(pixel_out),
                                    int'(line_a[(h_d2 + X_OFF[ck]) % 2048]));
            end
        end
    end

    task automatic apply_reset(input int chip);
        @(negedge clk_dvi);
        rst = 1'b0;
        ck = chip;
        chip_kind = video_timing_pkg::chip_kind_t'(chip);
        repeat (4) @(negedge clk_dvi);
        rst = 1'b1;
    endtask

    // counts line wraps seen by the model
    task automatic wait_rows(input int rows);
        int seen;
        int n;
        seen = 0;
        n = 0;
        while (!timed_out && seen < rows) begin
            @(negedge clk_dvi);
            n++;
            if (m_h == 0) seen++;
            if (n > (rows + 1) * (MAX_W[ck] + 1)) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: %0d output rows did not pass in %0d cycles", rows, n);
            end
        end
    endtask

    // n = cycles until hsync enters its pulse level
    task automatic wait_sync_lead(input bit pol, input int limit, output int n);
        logic prev;
        n = 0;
        prev = hsync;
        while (!timed_out) begin
            @(negedge clk_dvi);
            n++;
            if (hsync == pol && prev != pol) break;
            prev = hsync;
            if (n > limit) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: no hsync pulse within %0d cycles", limit);
            end
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        n_tests++;
        if (errors > e0) n_failed++;
        $display("test %s: %s, %0d errors", name, (errors > e0) ? "bad" : "ok", errors - e0);
    endtask

    task automatic run_sync_test(input string name, input int chip, input bit hp,
                                 input bit vp, input bit cs);
        int e0;
        int p;
        if (timed_out) return;
        e0 = errors;
        hpolarity = hp;
        vpolarity = vp;
        enable_csync = cs;
        apply_reset(chip);
        if (!cs) begin
            wait_sync_lead(hp, 2 * (MAX_W[ck] + 1), p);
            wait_sync_lead(hp, 2 * (MAX_W[ck] + 1), p);  // one full line
            assert (timed_out || p == MAX_W[ck] + 1)
                else flag_value("hsync period", p, MAX_W[ck] + 1);
        end
        wait_rows(MAX_H[ck] + 3);  // whole frame plus the v wrap
        finish_test(name, e0);
    endtask

    task automatic run_pixel_test(input string name, input int chip);
        int e0;
        logic [3:0] c;
        if (timed_out) return;
        e0 = errors;
        hpolarity = 1'b1;
        vpolarity = 1'b1;
        enable_csync = 1'b0;
        apply_reset(chip);
        for (int x = 0; x < 2048; x++) begin
            @(negedge clk_dvi);
            c = 4'($urandom);
            line_a[x] = c;
            pixel_we = 1'b1;
            pixel_x = 11'(x);
            pixel_in = c;
        end
        @(negedge clk_dvi);
        pixel_we = 1'b0;
        line_start = 1'b1;
        @(negedge clk_dvi);
        line_start = 1'b0;
        repeat (3) @(negedge clk_dvi);  // swap plus two read stages
        pix_chk = 1'b1;
        wait_rows(1);
        // second line into the other half, covers two full output rows
        for (int x = 0; x < 2048; x++) begin
            @(negedge clk_dvi);
            pixel_we = 1'b1;
            pixel_x = 11'(x);
            pixel_in = line_a[x] ^ 4'(1 + $urandom % 15);
        end
        @(negedge clk_dvi);
        pixel_we = 1'b0;
        pix_chk = 1'b0;
        finish_test(name, e0);
    endtask

    initial begin
        void'($urandom(SEED));
        run_sync_test("pal sync", 0, 1'b1, 1'b1, 1'b0);
        run_sync_test("ntsc r8 sync", 1, 1'b1, 1'b1, 1'b0);
        run_sync_test("ntsc r56 sync", 2, 1'b1, 1'b1, 1'b0);
        run_sync_test("pal csync", 0, 1'b1, 1'b1, 1'b1);
        run_sync_test("ntsc r8 low polarity", 1, 1'b0, 1'b0, 1'b0);
        run_sync_test("ntsc r56 low polarity csync", 2, 1'b0, 1'b0, 1'b1);
        run_pixel_test("ntsc r8 line doubling", 1);
        run_pixel_test("pal line doubling", 0);
        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (!timed_out && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/video_timing_pkg.sv
hw/pixel_pkg.sv
hw/scan_if.sv
hw/scan_counter.sv
hw/line_store.sv
hw/sync_shaper.sv
hw/dvi_line_doubler.sv
tests/tb_dvi_line_doubler.sv

//--- Makefile
# Verilator build and run for the DVI line doubler testbench

VERILATOR ?= verilator
TOP       ?= tb_dvi_line_doubler
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test FAILED

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) hw/*.sv tests/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
